//--- Makefile
VERILATOR  ?= verilator
TOP        ?= mhp_tb
RTL_TOP    ?= mhp_top
FILELIST   ?= mhp_top.f
OBJ_DIR    ?= obj_dir
INC_DIR    ?= common
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
PASS_MSG   ?= All tests passed
RTL_SRCS   ?= common/mhp_pkg.sv \
              rx_frame_reader/rx_frame_reader.sv \
              hdl/link_tracker.sv \
              reply_transmitter/reply_transmitter.sv \
              hdl/mhp_top.sv

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) +incdir+$(INC_DIR) --top-module $(RTL_TOP) $(RTL_SRCS)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- common/mhp_cfg.svh
`ifndef MHP_CFG_SVH
`define MHP_CFG_SVH

//////////////////////////////////////////////////
// receive side
//////////////////////////////////////////////////

// empty cycles after the last answered request that close a frame
`define MHP_IDLE_LIMIT 63

// header bytes: src(2) dst(2) size(2) type(1)
`define MHP_HDR_LEN 7

//////////////////////////////////////////////////
// transmit side
//////////////////////////////////////////////////

// send slot when the free-running counter is all ones
`define MHP_SLOT_BITS 6

`define MHP_REPLY_LEN 16

// min cycles between two o_wvalid pulses
`define MHP_BYTE_GAP 4

//////////////////////////////////////////////////
// frame type codes
//////////////////////////////////////////////////
`define MHP_TYPE_PING 8'h01
`define MHP_TYPE_GRANT 8'h04
`define MHP_TYPE_NOREPLY_BIT 4

`endif

//--- common/mhp_pkg.sv
`default_nettype none

package mhp_pkg;

  //////////////////////////////////////////////////
  // frame header
  //////////////////////////////////////////////////

  // field order follows the byte order on the wire
  typedef struct packed {
    logic [15:0] src_addr;
    logic [15:0] dst_addr;
    logic [15:0] size;
    logic [7:0]  d_type;
  } hdr_t;

  //////////////////////////////////////////////////
  // reply command
  //////////////////////////////////////////////////

  // values match the command codes of the protocol
  typedef enum logic [2:0] {
    CMD_NONE      = 3'd0,
    CMD_PING_RESP = 3'd1,
    CMD_ADDR_REQ  = 3'd3,
    CMD_GRANT_ACK = 3'd4
  } cmd_e;

  // request from link tracker to transmitter
  typedef struct packed {
    cmd_e cmd;
    hdr_t hdr;
  } reply_req_t;

  //////////////////////////////////////////////////
  // fsm states
  //////////////////////////////////////////////////
  typedef enum logic [1:0] {
    RX_IDLE,
    RX_TAKE,
    RX_GAP,
    RX_DONE
  } rx_state_e;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_SLOT,
    TX_BYTE,
    TX_GAP
  } tx_state_e;

endpackage

`default_nettype wire

//--- hdl/link_tracker.sv
`default_nettype none

`include "mhp_cfg.svh"

module link_tracker (
  input  wire                  i_clk,
  input  wire                  i_rst,
  input  mhp_pkg::hdr_t        i_hdr,
  input  wire                  i_frame_stb,
  output mhp_pkg::reply_req_t  o_req,
  output logic                 o_req_stb,
  output logic                 o_done
);

  import mhp_pkg::*;

  logic assigned;
  cmd_e next_cmd;
  logic is_grant;

  assign is_grant = (i_hdr.d_type == `MHP_TYPE_GRANT);

  //////////////////////////////////////////////////
  // reply selection
  //////////////////////////////////////////////////
  always_comb begin
    if (!assigned) begin
      // keep asking for an address until a grant shows up
      next_cmd = is_grant ? CMD_GRANT_ACK : CMD_ADDR_REQ;
    end else if (i_hdr.d_type[`MHP_TYPE_NOREPLY_BIT]) begin
      next_cmd = CMD_NONE;
    end else if (i_hdr.d_type == `MHP_TYPE_PING) begin
      next_cmd = CMD_PING_RESP;
    end else begin
      next_cmd = CMD_NONE;
    end
  end

  //////////////////////////////////////////////////
  // address state and strobe
  //////////////////////////////////////////////////
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      assigned  <= 1'b0;
      o_req_stb <= 1'b0;
    end else begin
      o_req_stb <= i_frame_stb && (next_cmd != CMD_NONE);
      if (i_frame_stb && !assigned && is_grant) begin
        assigned <= 1'b1;
      end
    end
  end

  // header copy for the transmitter
  always_ff @(posedge i_clk) begin
    if (i_frame_stb) begin
      o_req.cmd <= next_cmd;
      o_req.hdr <= i_hdr;
    end
  end

  assign o_done = assigned;

endmodule

`default_nettype wire

//--- hdl/mhp_top.sv
`default_nettype none

module mhp_top (
  input  wire        i_clk,
  input  wire        i_rst,
  input  wire        i_rready,
  input  wire [7:0]  i_rdata,
  input  wire        i_wready,
  output logic       o_rreq,
  output logic       o_wvalid,
  output logic [7:0] o_wdata,
  output logic       o_done
);

  import mhp_pkg::*;

  hdr_t       hdr;
  logic       frame_stb;
  reply_req_t req;
  logic       req_stb;
  logic       busy;

  //////////////////////////////////////////////////
  // receive, decide, reply
  //////////////////////////////////////////////////
  rx_frame_reader u_rx (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_rready    (i_rready),
    .i_rdata     (i_rdata),
    .i_busy      (busy),
    .o_rreq      (o_rreq),
    .o_hdr       (hdr),
    .o_frame_stb (frame_stb)
  );

  link_tracker u_link (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_hdr       (hdr),
    .i_frame_stb (frame_stb),
    .o_req       (req),
    .o_req_stb   (req_stb),
    .o_done      (o_done)
  );

  reply_transmitter u_tx (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_req     (req),
    .i_req_stb (req_stb),
    .i_wready  (i_wready),
    .o_wvalid  (o_wvalid),
    .o_wdata   (o_wdata),
    .o_busy    (busy)
  );

endmodule

`default_nettype wire

//--- mhp_top.f
+incdir+common
common/mhp_pkg.sv
rx_frame_reader/rx_frame_reader.sv
hdl/link_tracker.sv
reply_transmitter/reply_transmitter.sv
hdl/mhp_top.sv
sim/mhp_checker.sv
sim/mhp_monitor.sv
sim/mhp_tb.sv

//--- reply_transmitter/reply_transmitter.sv
`default_nettype none

`include "mhp_cfg.svh"

module reply_transmitter (
  input  wire                  i_clk,
  input  wire                  i_rst,
  input  mhp_pkg::reply_req_t  i_req,
  input  wire                  i_req_stb,
  input  wire                  i_wready,
  output logic                 o_wvalid,
  output logic [7:0]           o_wdata,
  output logic                 o_busy
);

  import mhp_pkg::*;

  localparam int unsigned IDX_W = $clog2(`MHP_REPLY_LEN + 1);
  localparam int unsigned GAP_W = $clog2(`MHP_BYTE_GAP);

  tx_state_e                state;
  reply_req_t               req_q;
  logic [`MHP_SLOT_BITS-1:0] slot_cnt;
  logic                     slot_hit;
  logic [IDX_W-1:0]         byte_idx;
  logic [GAP_W-1:0]         gap_cnt;
  logic [15:0]              sum;
  logic [7:0]               cur_byte;
  logic                     addr_req;
  logic                     grant;
  logic                     send;

  //////////////////////////////////////////////////
  // send slot strobe
  //////////////////////////////////////////////////
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      slot_cnt <= '0;
    end else begin
      slot_cnt <= slot_cnt + 1'b1;
    end
  end

  assign slot_hit = &slot_cnt;

  //////////////////////////////////////////////////
  // reply template
  //////////////////////////////////////////////////
  assign addr_req = (req_q.cmd == CMD_ADDR_REQ);
  assign grant    = (req_q.cmd == CMD_GRANT_ACK);

  always_comb begin
    cur_byte = 8'h00;
    case (byte_idx)
      // broadcast header until an address is known
      IDX_W'(0): cur_byte = addr_req ? 8'hff : req_q.hdr.src_addr[15:8];
      IDX_W'(1): cur_byte = addr_req ? 8'hff : req_q.hdr.src_addr[7:0];
      IDX_W'(2): cur_byte = addr_req ? 8'h00 : req_q.hdr.dst_addr[15:8];
      IDX_W'(3): cur_byte = addr_req ? 8'h00 : req_q.hdr.dst_addr[7:0];
      IDX_W'(5): cur_byte = grant ? 8'h02 : 8'h01;
      IDX_W'(6): begin
        if (grant) begin
          cur_byte = 8'h92;
        end else if (addr_req) begin
          cur_byte = 8'h83;
        end else begin
          cur_byte = 8'h81;
        end
      end
      IDX_W'(7): cur_byte = grant ? 8'h01 : 8'h00;
      IDX_W'(8): cur_byte = grant ? 8'h20 : 8'h00;
      // checksum trailer, high byte first
      IDX_W'(`MHP_REPLY_LEN - 2): cur_byte = sum[15:8];
      IDX_W'(`MHP_REPLY_LEN - 1): cur_byte = sum[7:0];
      default: cur_byte = 8'h00;
    endcase
  end

  // first byte waits for a slot, the rest only for room in the FIFO
  assign send = i_wready &&
                (((state == TX_SLOT) && slot_hit) || (state == TX_BYTE));

  //////////////////////////////////////////////////
  // pacing fsm
  //////////////////////////////////////////////////
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state    <= TX_IDLE;
      o_wvalid <= 1'b0;
      byte_idx <= '0;
      gap_cnt  <= '0;
    end else begin
      o_wvalid <= 1'b0;
      case (state)
        TX_IDLE: begin
          byte_idx <= '0;
          if (i_req_stb) begin
            state <= TX_SLOT;
          end
        end
        TX_SLOT, TX_BYTE: begin
          if (send) begin
            o_wvalid <= 1'b1;
            byte_idx <= byte_idx + 1'b1;
            gap_cnt  <= '0;
            state    <= TX_GAP;
          end
        end
        TX_GAP: begin
          if (byte_idx == IDX_W'(`MHP_REPLY_LEN)) begin
            state <= TX_IDLE;
          end else if (gap_cnt == GAP_W'(`MHP_BYTE_GAP - 2)) begin
            state <= TX_BYTE;
          end else begin
            gap_cnt <= gap_cnt + 1'b1;
          end
        end
        default: begin
          state <= TX_IDLE;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // request latch, data and checksum
  //////////////////////////////////////////////////
  always_ff @(posedge i_clk) begin
    if ((state == TX_IDLE) && i_req_stb) begin
      req_q <= i_req;
      sum   <= 16'h0000;
    end else if (send && (byte_idx < IDX_W'(`MHP_REPLY_LEN - 2))) begin
      sum <= sum + {8'h00, cur_byte};
    end
    if (send) begin
      o_wdata <= cur_byte;
    end
  end

  // strobe included so the reader is held off from the first cycle
  assign o_busy = (state != TX_IDLE) || i_req_stb;

endmodule

`default_nettype wire

//--- rx_frame_reader/rx_frame_reader.sv
`default_nettype none

`include "mhp_cfg.svh"

module rx_frame_reader (
  input  wire            i_clk,
  input  wire            i_rst,
  input  wire            i_rready,
  input  wire [7:0]      i_rdata,
  input  wire            i_busy,
  output logic           o_rreq,
  output mhp_pkg::hdr_t  o_hdr,
  output logic           o_frame_stb
);

  import mhp_pkg::*;

  localparam int unsigned CNT_W  = $clog2(`MHP_HDR_LEN + 1);
  localparam int unsigned IDLE_W = $clog2(`MHP_IDLE_LIMIT + 1);

  rx_state_e         state;
  logic [CNT_W-1:0]  byte_cnt;
  logic [IDLE_W-1:0] idle_cnt;
  logic              can_req;
  logic              take;

  // no new request while a reply is still on its way out
  assign can_req = i_rready && !i_busy;

  // second cycle of RX_TAKE, i_rdata valid
  assign take = (state == RX_TAKE) && !o_rreq;

  //////////////////////////////////////////////////
  // request and end-of-frame control
  //////////////////////////////////////////////////
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state       <= RX_IDLE;
      o_rreq      <= 1'b0;
      o_frame_stb <= 1'b0;
      byte_cnt    <= '0;
      idle_cnt    <= '0;
    end else begin
      o_frame_stb <= 1'b0;
      case (state)
        RX_IDLE: begin
          byte_cnt <= '0;
          if (can_req) begin
            o_rreq   <= 1'b1;
            idle_cnt <= '0;
            state    <= RX_TAKE;
          end
        end
        RX_TAKE: begin
          // first cycle is the request, second one carries the data
          idle_cnt <= idle_cnt + 1'b1;
          if (o_rreq) begin
            o_rreq <= 1'b0;
          end else begin
            // saturate, extra payload bytes are dropped
            if (byte_cnt != CNT_W'(`MHP_HDR_LEN)) begin
              byte_cnt <= byte_cnt + 1'b1;
            end
            state <= RX_GAP;
          end
        end
        RX_GAP: begin
          if (can_req) begin
            o_rreq   <= 1'b1;
            idle_cnt <= '0;
            state    <= RX_TAKE;
          end else if (idle_cnt == IDLE_W'(`MHP_IDLE_LIMIT - 1)) begin
            // short frames end here without a strobe
            o_frame_stb <= (byte_cnt == CNT_W'(`MHP_HDR_LEN));
            state       <= RX_DONE;
          end else begin
            idle_cnt <= idle_cnt + 1'b1;
          end
        end
        RX_DONE: begin
          state <= RX_IDLE;
        end
        default: begin
          state <= RX_IDLE;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // header capture
  //////////////////////////////////////////////////

  // big endian fields, src first
  always_ff @(posedge i_clk) begin
    if (take) begin
      case (byte_cnt)
        CNT_W'(0): o_hdr.src_addr[15:8] <= i_rdata;
        CNT_W'(1): o_hdr.src_addr[7:0]  <= i_rdata;
        CNT_W'(2): o_hdr.dst_addr[15:8] <= i_rdata;
        CNT_W'(3): o_hdr.dst_addr[7:0]  <= i_rdata;
        CNT_W'(4): o_hdr.size[15:8]     <= i_rdata;
        CNT_W'(5): o_hdr.size[7:0]      <= i_rdata;
        CNT_W'(6): o_hdr.d_type         <= i_rdata;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- sim/mhp_checker.sv
`default_nettype none

module mhp_checker (
  input wire i_clk,
  input wire i_rst,
  input wire i_rreq,
  input wire i_wvalid,
  input wire i_busy,
  input wire i_done
);

  //////////////////////////////////////////////////
  // transmit pacing
  //////////////////////////////////////////////////

  // bytes are spread out by the byte gap
  a_wvalid_gap: assert property (
    @(posedge i_clk) disable iff (i_rst)
    i_wvalid |=> !i_wvalid
  ) else $error("o_wvalid high on two consecutive cycles");

  //////////////////////////////////////////////////
  // one frame in flight
  //////////////////////////////////////////////////
  a_no_read_while_busy: assert property (
    @(posedge i_clk) disable iff (i_rst)
    i_busy |-> !i_rreq
  ) else $error("o_rreq raised while a reply is pending");

  // address stays assigned until the next reset
  a_done_sticky: assert property (
    @(posedge i_clk) disable iff (i_rst)
    i_done |=> i_done
  ) else $error("o_done fell without a reset");

endmodule

bind mhp_top mhp_checker chk0 (
  .i_clk    (i_clk),
  .i_rst    (i_rst),
  .i_rreq   (o_rreq),
  .i_wvalid (o_wvalid),
  .i_busy   (busy),
  .i_done   (o_done)
);

`default_nettype wire

//--- sim/mhp_monitor.sv
`default_nettype none

`include "mhp_cfg.svh"

module mhp_monitor (
  input  wire                i_clk,
  input  wire                i_rst,
  input  wire                i_rreq,
  input  wire                i_wvalid,
  input  wire [7:0]          i_wdata,
  input  wire                i_done,
  input  wire                i_arm,
  input  wire                i_close,
  input  wire [127:0]        i_name,
  input  mhp_pkg::hdr_t      i_exp_hdr,
  input  mhp_pkg::cmd_e      i_exp_cmd,
  input  wire [3:0]          i_exp_len,
  input  wire                i_exp_done,
  output int                 o_wcount,
  output int                 o_pass_cnt,
  output int                 o_fail_cnt
);

  import mhp_pkg::*;

  logic [127:0] name_q;
  logic [127:0] exp_reply;
  int           exp_count;
  int           exp_len_q;
  logic         exp_done_q;
  int           rcount;
  int           errs;
  logic         rst_q;

  //////////////////////////////////////////////////
  // expected reply, byte 0 in the top bits
  //////////////////////////////////////////////////
  function automatic logic [127:0] build_reply(input hdr_t h, input cmd_e c);
    logic [7:0]   b [`MHP_REPLY_LEN];
    logic [15:0]  sum;
    logic [127:0] flat;
    int           k;
    for (k = 0; k < `MHP_REPLY_LEN; k++) begin
      b[k] = 8'h00;
    end
    // broadcast addresses when asking for one
    if (c == CMD_ADDR_REQ) begin
      b[0] = 8'hff;
      b[1] = 8'hff;
    end else begin
      b[0] = h.src_addr[15:8];
      b[1] = h.src_addr[7:0];
      b[2] = h.dst_addr[15:8];
      b[3] = h.dst_addr[7:0];
    end
    case (c)
      CMD_PING_RESP: begin
        b[5] = 8'h01;
        b[6] = 8'h81;
      end
      CMD_ADDR_REQ: begin
        b[5] = 8'h01;
        b[6] = 8'h83;
      end
      CMD_GRANT_ACK: begin
        b[5] = 8'h02;
        b[6] = 8'h92;
        b[7] = 8'h01;
        b[8] = 8'h20;
      end
      default: ;
    endcase
    sum = 16'h0000;
    for (k = 0; k < `MHP_REPLY_LEN - 2; k++) begin
      sum = sum + {8'h00, b[k]};
    end
    b[`MHP_REPLY_LEN - 2] = sum[15:8];
    b[`MHP_REPLY_LEN - 1] = sum[7:0];
    for (k = 0; k < `MHP_REPLY_LEN; k++) begin
      flat[127 - 8 * k -: 8] = b[k];
    end
    return flat;
  endfunction

  initial begin
    o_wcount   = 0;
    o_pass_cnt = 0;
    o_fail_cnt = 0;
    rcount     = 0;
    errs       = 0;
    rst_q      = 1'b1;
  end

  //////////////////////////////////////////////////
  // per-test tracking
  //////////////////////////////////////////////////
  always @(posedge i_clk) begin
    if (i_arm) begin
      name_q     = i_name;
      exp_reply  = build_reply(i_exp_hdr, i_exp_cmd);
      exp_count  = (i_exp_cmd == CMD_NONE) ? 0 : `MHP_REPLY_LEN;
      exp_len_q  = int'(i_exp_len);
      exp_done_q = i_exp_done;
      o_wcount   = 0;
      rcount     = 0;
      errs       = 0;
    end
    // first cycle out of reset
    if (rst_q && !i_rst && (i_rreq || i_wvalid || i_done)) begin
      $display("outputs not all low after reset");
      errs++;
    end
    rst_q = i_rst;
    if (!i_rst) begin
      if (i_rreq) begin
        rcount++;
      end
      if (i_wvalid) begin
        if (o_wcount < exp_count) begin
          if (i_wdata !== exp_reply[127 - 8 * o_wcount -: 8]) begin
            $display("FAIL %0s byte %0d expected %02h actual %02h", name_q, o_wcount,
                     exp_reply[127 - 8 * o_wcount -: 8], i_wdata);
            errs++;
          end
        end else begin
          $display("%0s: reply byte %0d arrived beyond the expected %0d bytes",
                   name_q, o_wcount, exp_count);
          errs++;
        end
        o_wcount++;
      end
    end
    if (i_close) begin
      if (o_wcount != exp_count) begin
        $display("FAIL %0s reply length expected %0d actual %0d", name_q, exp_count, o_wcount);
        errs++;
      end
      if (rcount != exp_len_q) begin
        $display("FAIL %0s bytes read expected %0d actual %0d", name_q, exp_len_q, rcount);
        errs++;
      end
      if (i_done !== exp_done_q) begin
        $display("FAIL %0s o_done expected %0b actual %0b", name_q, exp_done_q, i_done);
        errs++;
      end
      if (errs == 0) begin
        $display("PASS %0s", name_q);
        o_pass_cnt++;
      end else begin
        $display("test %0s failed with %0d errors", name_q, errs);
        o_fail_cnt++;
      end
    end
  end

endmodule

`default_nettype wire

//--- sim/mhp_tb.sv
`default_nettype none

`include "mhp_cfg.svh"

module mhp_tb;

  import mhp_pkg::*;

  localparam int MAX_ROWS      = 12;
  localparam int RX_TIMEOUT    = 200;
  localparam int REPLY_TIMEOUT = 4000;
  // long enough for the idle timeout plus a few send slots
  localparam int QUIET_WINDOW  = `MHP_IDLE_LIMIT + 600;

  // frame bytes left aligned, byte 0 in bits 95:88
  typedef struct packed {
    logic [127:0] name;
    logic [95:0]  data;
    logic [3:0]   len;
    cmd_e         cmd;
    logic         done;
  } row_t;

  logic         clk = 1'b0;
  logic         rst;
  logic         rready;
  logic [7:0]   rdata;
  logic         wready;
  wire          rreq;
  wire          wvalid;
  wire  [7:0]   wdata;
  wire          done;

  logic         arm;
  logic         close;
  logic [127:0] cur_name;
  hdr_t         cur_hdr;
  cmd_e         cur_cmd;
  logic [3:0]   cur_len;
  logic         cur_done;
  int           wcount;
  int           pass_cnt;
  int           fail_cnt;
  int           timeouts;
  int           n_rows;
  logic [31:0]  rng;
  row_t         rows [MAX_ROWS];

  always #50 clk = ~clk;

  mhp_top dut0 (
    .i_clk    (clk),
    .i_rst    (rst),
    .i_rready (rready),
    .i_rdata  (rdata),
    .i_wready (wready),
    .o_rreq   (rreq),
    .o_wvalid (wvalid),
    .o_wdata  (wdata),
    .o_done   (done)
  );

  mhp_monitor mon0 (
    .i_clk      (clk),
    .i_rst      (rst),
    .i_rreq     (rreq),
    .i_wvalid   (wvalid),
    .i_wdata    (wdata),
    .i_done     (done),
    .i_arm      (arm),
    .i_close    (close),
    .i_name     (cur_name),
    .i_exp_hdr  (cur_hdr),
    .i_exp_cmd  (cur_cmd),
    .i_exp_len  (cur_len),
    .i_exp_done (cur_done),
    .o_wcount   (wcount),
    .o_pass_cnt (pass_cnt),
    .o_fail_cnt (fail_cnt)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // random back-pressure on the transmit FIFO
  initial begin
    wready = 1'b0;
    rng    = 32'd60;
    forever begin
      @(negedge clk);
      rng    = xorshift32(rng);
      wready = rng[7];
    end
  end

  //////////////////////////////////////////////////
  // stimulus table
  //////////////////////////////////////////////////

  // bytes given right aligned, shifted up to byte 0
  task automatic add_row(input logic [127:0] name, input logic [95:0] bytes_r,
                         input int len, input cmd_e cmd, input logic exp_done);
    row_t r;
    r.name = name;
    r.data = bytes_r << (8 * (12 - len));
    r.len  = 4'(len);
    r.cmd  = cmd;
    r.done = exp_done;
    rows[n_rows] = r;
    n_rows++;
  endtask

  task automatic build_table();
    add_row("idle",            96'h0,                           0, CMD_NONE,      1'b0);
    add_row("ping_unassigned", 96'h1234_5678_0000_01,           7, CMD_ADDR_REQ,  1'b0);
    add_row("grant",           96'h0001_002a_0000_04,           7, CMD_GRANT_ACK, 1'b1);
    add_row("ping_payload",    96'h0001_002a_0003_01_a5_5a_c3,  10, CMD_PING_RESP, 1'b1);
    add_row("noreply_type",    96'h0001_002a_0000_11,           7, CMD_NONE,      1'b1);
    add_row("short_frame",     96'h0001_002a_00,                5, CMD_NONE,      1'b1);
    add_row("ping_after",      96'h0005_002a_0000_01,           7, CMD_PING_RESP, 1'b1);
    add_row("other_type",      96'h0001_002a_0000_02,           7, CMD_NONE,      1'b1);
    add_row("ping_bp_high",    96'hfffe_ff80_0000_01_11_22,     9, CMD_PING_RESP, 1'b1);
    add_row("ping_bp_mixed",   96'h7f80_c3a5_0102_01,           7, CMD_PING_RESP, 1'b1);
  endtask

  //////////////////////////////////////////////////
  // one row through the receive FIFO model
  //////////////////////////////////////////////////
  task automatic run_row(input row_t r);
    int ptr;
    int guard;
    int exp_bytes;
    ptr       = 0;
    exp_bytes = (r.cmd == CMD_NONE) ? 0 : `MHP_REPLY_LEN;
    cur_name  = r.name;
    cur_hdr   = hdr_t'(r.data[95:40]);
    cur_cmd   = r.cmd;
    cur_len   = r.len;
    cur_done  = r.done;
    arm       = 1'b1;
    @(negedge clk);
    arm    = 1'b0;
    rready = (r.len != 4'd0);
    // next byte shows up the cycle after each request
    guard = 0;
    while ((ptr < int'(r.len)) && (guard < RX_TIMEOUT)) begin
      @(negedge clk);
      guard++;
      if (rreq) begin
        rdata  = r.data[95 - 8 * ptr -: 8];
        ptr++;
        rready = (ptr < int'(r.len));
      end
    end
    if (ptr < int'(r.len)) begin
      $display("timeout: %0s, the receive FIFO was not drained", r.name);
      timeouts++;
      rready = 1'b0;
    end
    guard = 0;
    if (exp_bytes != 0) begin
      // FIFO looks non-empty while the reply goes out
      // the reader has to hold off its requests until the last byte
      while ((wcount < exp_bytes) && (guard < REPLY_TIMEOUT)) begin
        @(negedge clk);
        guard++;
        rready = (wcount > 0) && (wcount < exp_bytes);
      end
      rready = 1'b0;
      if (wcount < exp_bytes) begin
        $display("timeout: %0s, reply incomplete after %0d cycles", r.name, guard);
        timeouts++;
      end
    end else begin
      // no reply expected, any byte ends the window early
      while ((wcount == 0) && (guard < QUIET_WINDOW)) begin
        @(negedge clk);
        guard++;
      end
    end
    repeat (2 * `MHP_BYTE_GAP) @(negedge clk);
    close = 1'b1;
    @(negedge clk);
    close = 1'b0;
  endtask

  initial begin
    int i;
    rst      = 1'b1;
    rready   = 1'b0;
    rdata    = 8'h00;
    arm      = 1'b0;
    close    = 1'b0;
    cur_name = '0;
    cur_hdr  = '0;
    cur_cmd  = CMD_NONE;
    cur_len  = 4'd0;
    cur_done = 1'b0;
    timeouts = 0;
    n_rows   = 0;
    build_table();
    repeat (8) @(negedge clk);
    rst = 1'b0;
    for (i = 0; i < n_rows; i++) begin
      run_row(rows[i]);
    end
    @(negedge clk);
    $display("tests: %0d run, %0d passed, %0d failed, %0d timeouts",
             n_rows, pass_cnt, fail_cnt, timeouts);
    if ((fail_cnt == 0) && (timeouts == 0) && (pass_cnt == n_rows)) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
